/* hw/memPkg.sv */
// Bit 0 is the MSB of every bus word; only 32K words exist and ECC, parity and bursts are absent
package memPkg;

   //////////////////////////////
   // Sizes and addresses
   //////////////////////////////

   // Implemented main memory, the rest of the 22-bit space is nonexistent
   localparam int memWords    = 32768;
   localparam int memAddrBits = 15;

   // Memory status register sits at device 0, register 100000 (octal)
   localparam logic [0:3]  statusDev = 4'd0;
   localparam logic [0:17] statusReg = 18'o100000;

   //////////////////////////////
   // Wait timing
   //////////////////////////////

   // Width of the wait timer count
   localparam int timerBits = 4;

   // Enabled edges of wait for a main memory access
   localparam logic [0:timerBits-1] memWaitStates = 4'd2;

   // Enabled edges before an unclaimed cycle is reported as nonexistent
   localparam logic [0:timerBits-1] nxmTimeout = 4'd8;

   // Sequencer state codes
   localparam int seqStateBits = 3;
   localparam logic [0:seqStateBits-1] stIdle   = 3'd0;
   localparam logic [0:seqStateBits-1] stDecode = 3'd1;
   localparam logic [0:seqStateBits-1] stWait   = 3'd2;
   localparam logic [0:seqStateBits-1] stStatus = 3'd3;
   localparam logic [0:seqStateBits-1] stNxm    = 3'd4;
   localparam logic [0:seqStateBits-1] stFinish = 3'd5;
   localparam logic [0:seqStateBits-1] stDone   = 3'd6;

   //////////////////////////////
   // Bus word types
   //////////////////////////////

   // One 36-bit bus word
   typedef logic [0:35] busWord_t;

   // Cycle flags in bits 0 to 13 of the address word
   typedef struct packed {
      logic [0:2] spare0;
      logic       rdCyc;
      logic       spare1;
      logic       wrCyc;
      logic [0:3] spare2;
      logic       ioCyc;
      logic [0:2] spare3;
   } busFlags_t;

   // Memory cycle, 22-bit physical address
   typedef struct packed {
      busFlags_t   flags;
      logic [0:21] memAddr;
   } memView_t;

   // IO cycle, device number and register address
   typedef struct packed {
      busFlags_t   flags;
      logic [0:3]  ioDev;
      logic [0:17] ioReg;
   } ioView_t;

   // ioCyc picks which view is meaningful
   typedef union packed {
      memView_t mem;
      ioView_t  io;
   } busAddr_u;

   // Command from sequencer to the memory array
   typedef struct packed {
      logic                   we;
      logic [0:memAddrBits-1] addr;
      busWord_t               wdata;
   } memCmd_t;

endpackage

/* hw/waitTimer.sv */
// Count advances only on clken edges; a load of zero never raises timerDone
module waitTimer (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         clken,
   input  logic                         timerLoad,
   input  logic [0:memPkg::timerBits-1] timerCount,
   output logic                         timerDone
);

   // Remaining wait cycles
   logic [0:memPkg::timerBits-1] count;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         count     <= '0;
         timerDone <= 1'b0;
      end
      else if (clken)
      begin
         // Done is a single enabled-cycle pulse
         timerDone <= 1'b0;
         if (timerLoad)
            count <= timerCount;
         else if (count != '0)
         begin
            count <= count - 1'b1;
            // Last step down to zero
            if (count == 1)
               timerDone <= 1'b1;
         end
      end
   end

endmodule

/* hw/memArray.sv */
// Internal array stands in for the SSRAM; contents are undefined after power-up and never reset
module memArray (
   input  logic             clk,
   input  logic             clken,
   input  memPkg::memCmd_t  memCmd,
   input  logic             memRd,
   output memPkg::busWord_t memRdData
);

   //////////////////////////////
   // Storage
   //////////////////////////////

   // Main memory words
   memPkg::busWord_t mem [memPkg::memWords];

   // Write port
   always_ff @(posedge clk)
   begin
      if (clken && memCmd.we)
      begin
         mem[memCmd.addr] <= memCmd.wdata;
      end
   end

   //////////////////////////////
   // Read port
   //////////////////////////////

   // Registered read, holds until the next memRd
   always_ff @(posedge clk)
   begin
      if (clken && memRd)
      begin
         memRdData <= mem[memCmd.addr];
      end
   end

endmodule

/* hw/memStatus.sv */
// Only PE, EE and PF are kept; EH, UE, RE, ECP, FCB and ERA always read zero
module memStatus (
   input  logic             clk,
   input  logic             rst,
   input  logic             clken,
   input  logic             statWe,
   input  memPkg::busWord_t busDataIn,
   output memPkg::busWord_t statWord
);

   // Parity error
   logic statPe;
   // ECC enable, inverse of the last ED written
   logic statEe;
   // Power failure, set at power-up
   logic statPf;

   //////////////////////////////
   // Write rules
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         statPe <= 1'b0;
         statEe <= 1'b1;
         statPf <= 1'b1;
      end
      else if (clken && statWe)
      begin
         // PE follows bit 3
         statPe <= busDataIn[3];
         // Zero in bit 12 clears PF, a one never sets it again
         statPf <= busDataIn[12] & statPf;
         // ED in bit 35 disables ECC
         statEe <= ~busDataIn[35];
      end
   end

   //////////////////////////////
   // Read layout
   //////////////////////////////

   always_comb
   begin
      statWord     = '0;
      statWord[3]  = statPe;
      statWord[4]  = statEe;
      statWord[12] = statPf;
   end

endmodule

/* hw/memSequencer.sv */
// One cycle in flight; requester must hold busReq, busAddr and busDataIn until busAck or busNxm
module memSequencer (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         clken,
   input  logic                         busReq,
   input  memPkg::busAddr_u             busAddr,
   input  memPkg::busWord_t             busDataIn,
   input  memPkg::busWord_t             memRdData,
   input  memPkg::busWord_t             statWord,
   input  logic                         timerDone,
   output logic                         busAck,
   output logic                         busNxm,
   output memPkg::busWord_t             busDataOut,
   output memPkg::memCmd_t              memCmd,
   output logic                         memRd,
   output logic                         statWe,
   output logic                         timerLoad,
   output logic [0:memPkg::timerBits-1] timerCount
);

   logic [0:memPkg::seqStateBits-1] state;
   memPkg::memView_t memView;
   memPkg::ioView_t  ioView;
   logic isIo;
   logic hitStat;
   logic hitMem;
   logic inDecode;

   //////////////////////////////
   // Address decode
   //////////////////////////////

   // Same word seen two ways
   assign memView  = busAddr.mem;
   assign ioView   = busAddr.io;
   assign isIo     = ioView.flags.ioCyc;
   assign inDecode = (state == memPkg::stDecode);

   // Status register claims its one IO address
   assign hitStat = isIo && (ioView.ioDev == memPkg::statusDev)
                        && (ioView.ioReg == memPkg::statusReg);

   // Memory claims only the implemented words
   assign hitMem = !isIo && (memView.memAddr < memPkg::memWords);

   // Array command and strobes, live for the decode state only
   always_comb
   begin
      memCmd.we    = inDecode && hitMem && memView.flags.wrCyc;
      memCmd.addr  = memView.memAddr[22-memPkg::memAddrBits:21];
      memCmd.wdata = busDataIn;
      memRd        = inDecode && hitMem && memView.flags.rdCyc;
      statWe       = inDecode && hitStat && ioView.flags.wrCyc;
      // Timer covers memory waits and the NXM timeout
      timerLoad    = inDecode && !hitStat;
      timerCount   = hitMem ? memPkg::memWaitStates : memPkg::nxmTimeout;
   end

   //////////////////////////////
   // Cycle FSM
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state  <= memPkg::stIdle;
         busAck <= 1'b0;
         busNxm <= 1'b0;
      end
      else if (clken)
      begin
         case (state)
            memPkg::stIdle:
               if (busReq)
                  state <= memPkg::stDecode;
            // Pick the target of the cycle
            memPkg::stDecode:
               if (hitStat)
                  state <= memPkg::stStatus;
               else if (hitMem)
                  state <= memPkg::stWait;
               else
                  state <= memPkg::stNxm;
            memPkg::stWait:
               if (timerDone)
               begin
                  busAck <= 1'b1;
                  state  <= memPkg::stFinish;
               end
            // Write already applied in decode
            memPkg::stStatus:
            begin
               busAck <= 1'b1;
               state  <= memPkg::stFinish;
            end
            memPkg::stNxm:
               if (timerDone)
               begin
                  busNxm <= 1'b1;
                  state  <= memPkg::stFinish;
               end
            // End the pulse
            memPkg::stFinish:
            begin
               busAck <= 1'b0;
               busNxm <= 1'b0;
               state  <= memPkg::stDone;
            end
            // No new cycle until the request drops
            memPkg::stDone:
               if (!busReq)
                  state <= memPkg::stIdle;
            default:
               state <= memPkg::stIdle;
         endcase
      end
   end

   // Read data, held between acknowledges
   always_ff @(posedge clk)
   begin
      if (clken && (state == memPkg::stWait) && timerDone && memView.flags.rdCyc)
         busDataOut <= memRdData;
      else if (clken && (state == memPkg::stStatus) && ioView.flags.rdCyc)
         busDataOut <= statWord;
   end

endmodule

/* hw/memTop.sv */
// Plain request level with acknowledge or NXM pulse; all state advances only while clken is high
module memTop (
   input  logic             clk,
   input  logic             rst,
   input  logic             clken,
   input  logic             busReq,
   input  memPkg::busAddr_u busAddr,
   input  memPkg::busWord_t busDataIn,
   output logic             busAck,
   output logic             busNxm,
   output memPkg::busWord_t busDataOut
);

   //////////////////////////////
   // Internal nets
   //////////////////////////////

   // Array side
   memPkg::memCmd_t  memCmd;
   logic             memRd;
   memPkg::busWord_t memRdData;
   // Status register side
   logic             statWe;
   memPkg::busWord_t statWord;
   // Wait timer side
   logic                         timerLoad;
   logic [0:memPkg::timerBits-1] timerCount;
   logic                         timerDone;

   // Cycle control
   memSequencer u_seq (
      .clk        (clk),
      .rst        (rst),
      .clken      (clken),
      .busReq     (busReq),
      .busAddr    (busAddr),
      .busDataIn  (busDataIn),
      .memRdData  (memRdData),
      .statWord   (statWord),
      .timerDone  (timerDone),
      .busAck     (busAck),
      .busNxm     (busNxm),
      .busDataOut (busDataOut),
      .memCmd     (memCmd),
      .memRd      (memRd),
      .statWe     (statWe),
      .timerLoad  (timerLoad),
      .timerCount (timerCount)
   );

   // Wait states and NXM timeout
   waitTimer u_timer (
      .clk        (clk),
      .rst        (rst),
      .clken      (clken),
      .timerLoad  (timerLoad),
      .timerCount (timerCount),
      .timerDone  (timerDone)
   );

   // Main memory
   memArray u_array (
      .clk       (clk),
      .clken     (clken),
      .memCmd    (memCmd),
      .memRd     (memRd),
      .memRdData (memRdData)
   );

   // Status register takes write data straight from the bus
   memStatus u_status (
      .clk       (clk),
      .rst       (rst),
      .clken     (clken),
      .statWe    (statWe),
      .busDataIn (busDataIn),
      .statWord  (statWord)
   );

endmodule

/* verif/clockGen.sv */
// Free-running testbench clock that starts low at time zero with a fixed 100 ns period
module clockGen (
   output logic clk
);

   timeunit 1ns;
   timeprecision 100ps;

   // Half of the 100 ns period
   localparam int halfPeriod = 50;

   initial
   begin
      clk = 1'b0;
      forever
         #halfPeriod clk = ~clk;
   end

endmodule

/* verif/memTbTasks.svh */
// Included inside memTb; tasks expect clken high between cycles and busReq low on entry
`ifndef MEM_TB_TASKS_SVH
`define MEM_TB_TASKS_SVH

//////////////////////////////
// Reference models
//////////////////////////////

// Main memory words written so far
memPkg::busWord_t memModel [int];
// Status bits as they come out of reset
logic modelPe = 1'b0;
logic modelEe = 1'b1;
logic modelPf = 1'b1;

// Expectations seen by the checkers
int               expLat  = 0;
bit               expNxm  = 1'b0;
bit               expRead = 1'b0;
memPkg::busWord_t expData = '0;

// Error and test counters
int failCount      = 0;
int testStartFails = 0;
int testsPassed    = 0;
int testsFailed    = 0;

// Memory cycle address word
function automatic memPkg::busAddr_u memAddrWord(input bit wr, input logic [21:0] addr);
   memPkg::busAddr_u a;
   a = '0;
   a.mem.flags.rdCyc = !wr;
   a.mem.flags.wrCyc = wr;
   a.mem.memAddr     = addr;
   return a;
endfunction

// IO cycle address word
function automatic memPkg::busAddr_u ioAddrWord(input bit wr, input logic [3:0] dev,
                                                input logic [17:0] regAddr);
   memPkg::busAddr_u a;
   a = '0;
   a.io.flags.rdCyc = !wr;
   a.io.flags.wrCyc = wr;
   a.io.flags.ioCyc = 1'b1;
   a.io.ioDev       = dev;
   a.io.ioReg       = regAddr;
   return a;
endfunction

// PE at bit 3, EE at bit 4, PF at bit 12
function automatic memPkg::busWord_t statusExpected();
   memPkg::busWord_t w;
   w     = '0;
   w[3]  = modelPe;
   w[4]  = modelEe;
   w[12] = modelPf;
   return w;
endfunction

task automatic reportMismatch(input string sigName, input logic [35:0] expVal,
                              input logic [35:0] actVal);
   $display("[FAIL] %0d ns %s expected %o got %o", $time, sigName, expVal, actVal);
   failCount++;
endtask

//////////////////////////////
// Bus cycles
//////////////////////////////

// Raise the request, wait for ACK or NXM, optionally hold, then drop
task automatic runCycle(input memPkg::busAddr_u addrWord, input memPkg::busWord_t wdata,
                        input int holdCycles);
   int waited;
   int i;
   busAddr   = addrWord;
   busDataIn = wdata;
   busReq    = 1'b1;
   waited    = 0;
   while (!busAck && !busNxm && waited < busTimeout)
   begin
      @(negedge clk);
      waited++;
   end
   if (waited >= busTimeout)
   begin
      $display("Timeout: DUT gave neither acknowledge nor NXM within %0d clocks", busTimeout);
      busReq = 1'b0;
      endRun(1'b1);
   end
   else
   begin
      for (i = 0; i < holdCycles; i++)
         @(negedge clk);
      busReq = 1'b0;
      // Sequencer passes finish and done before it is idle again
      for (i = 0; i < 2; i++)
         @(negedge clk);
   end
endtask

task automatic memWrite(input logic [21:0] addr, input memPkg::busWord_t data);
   expRead = 1'b0;
   expNxm  = (addr >= memPkg::memWords);
   expLat  = expNxm ? memPkg::nxmTimeout + 2 : memPkg::memWaitStates + 2;
   if (!expNxm)
      memModel[int'(addr)] = data;
   runCycle(memAddrWord(1'b1, addr), data, 0);
endtask

// Only addresses already in the model are read
task automatic memRead(input logic [21:0] addr, input int holdCycles);
   expRead = 1'b1;
   expNxm  = 1'b0;
   expLat  = memPkg::memWaitStates + 2;
   expData = memModel[int'(addr)];
   runCycle(memAddrWord(1'b0, addr), '0, holdCycles);
endtask

task automatic ioWrite(input logic [3:0] dev, input logic [17:0] regAddr,
                       input memPkg::busWord_t data);
   expRead = 1'b0;
   expNxm  = !(dev == memPkg::statusDev && regAddr == memPkg::statusReg);
   expLat  = expNxm ? memPkg::nxmTimeout + 2 : 2;
   if (!expNxm)
   begin
      modelPe = data[3];
      // PF can only be cleared
      modelPf = modelPf & data[12];
      modelEe = ~data[35];
   end
   runCycle(ioAddrWord(1'b1, dev, regAddr), data, 0);
endtask

task automatic ioRead(input logic [3:0] dev, input logic [17:0] regAddr);
   expNxm  = !(dev == memPkg::statusDev && regAddr == memPkg::statusReg);
   expRead = !expNxm;
   expLat  = expNxm ? memPkg::nxmTimeout + 2 : 2;
   expData = statusExpected();
   runCycle(ioAddrWord(1'b0, dev, regAddr), '0, 0);
endtask

// Drop clken for a while once the cycle is under way
task automatic stallClock(input int startDelay, input int stallLen);
   int i;
   for (i = 0; i < startDelay; i++)
      @(negedge clk);
   clken = 1'b0;
   for (i = 0; i < stallLen; i++)
      @(negedge clk);
   clken = 1'b1;
endtask

task automatic beginTest();
   testStartFails = failCount;
endtask

task automatic endTest(input string name);
   if (failCount == testStartFails)
   begin
      testsPassed++;
      $display("Test %s: ok", name);
   end
   else
   begin
      testsFailed++;
      $display("Test %s: %0d errors", name, failCount - testStartFails);
   end
endtask

`endif

/* verif/memTb.sv */
// Self-checking testbench; stimulus changes on falling edges and clken drops only in the stall test
module memTb;

   timeunit 1ns;
   timeprecision 100ps;

   // Clocks to wait for ACK or NXM, and reset length
   localparam int busTimeout  = 50;
   localparam int resetCycles = 16;

   logic             clk;
   logic             rst;
   logic             clken;
   logic             busReq;
   memPkg::busAddr_u busAddr;
   memPkg::busWord_t busDataIn;
   logic             busAck;
   logic             busNxm;
   memPkg::busWord_t busDataOut;

   // Enabled edges since the request rose, and acknowledge pulses seen
   int   edgeCount;
   int   ackTotal = 0;
   logic ackPrev  = 1'b0;

   `include "memTbTasks.svh"

   clockGen u_clk (
      .clk (clk)
   );

   memTop u_dut (
      .clk        (clk),
      .rst        (rst),
      .clken      (clken),
      .busReq     (busReq),
      .busAddr    (busAddr),
      .busDataIn  (busDataIn),
      .busAck     (busAck),
      .busNxm     (busNxm),
      .busDataOut (busDataOut)
   );

   // Count includes edge 0, where the idle FSM samples the request
   always @(posedge clk)
   begin
      if (rst || !busReq)
         edgeCount <= 0;
      else if (clken)
         edgeCount <= edgeCount + 1;
   end

   always @(negedge clk)
   begin
      if (busAck && !ackPrev)
         ackTotal <= ackTotal + 1;
      ackPrev <= busAck;
   end

   //////////////////////////////
   // Checkers
   //////////////////////////////

   assert property (@(posedge clk) disable iff (rst) !(busAck && busNxm))
      else reportMismatch("busAck&busNxm", 36'd0, 36'd1);
   // Strobes last one enabled cycle
   assert property (@(posedge clk) disable iff (rst) (busAck && clken) |=> !busAck)
      else reportMismatch("busAck", 36'd0, 36'd1);
   assert property (@(posedge clk) disable iff (rst) (busNxm && clken) |=> !busNxm)
      else reportMismatch("busNxm", 36'd0, 36'd1);
   // Right strobe for the cycle kind
   assert property (@(posedge clk) disable iff (rst) $rose(busAck) |-> !expNxm)
      else reportMismatch("busAck", 36'd0, 36'd1);
   assert property (@(posedge clk) disable iff (rst) $rose(busNxm) |-> expNxm)
      else reportMismatch("busNxm", 36'd0, 36'd1);
   // Fixed latency in enabled edges
   assert property (@(posedge clk) disable iff (rst)
                    $rose(busAck || busNxm) |-> edgeCount == expLat + 1)
      else reportMismatch("edgeCount", 36'(expLat + 1), 36'($sampled(edgeCount)));
   assert property (@(posedge clk) disable iff (rst)
                    ($rose(busAck) && expRead) |-> busDataOut == expData)
      else reportMismatch("busDataOut", expData, $sampled(busDataOut));

   task automatic endRun(input bit timedOut);
      $display("Summary: %0d tests passed, %0d tests failed", testsPassed, testsFailed);
      if (failCount == 0 && !timedOut)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   endtask

   //////////////////////////////
   // Stimulus
   //////////////////////////////

   initial
   begin : mainSeq
      int               seed;
      int               i;
      int               pick;
      int               ackBefore;
      logic [31:0]      hiRand;
      logic [31:0]      loRand;
      logic [21:0]      tmpAddr;
      logic [21:0]      addrList [20];
      memPkg::busWord_t data;
      seed      = 46;
      rst       = 1'b1;
      clken     = 1'b1;
      busReq    = 1'b0;
      busAddr   = '0;
      busDataIn = '0;
      for (i = 0; i < resetCycles; i++)
         @(negedge clk);
      rst = 1'b0;

      beginTest();
      ioRead(memPkg::statusDev, memPkg::statusReg);
      endTest("status after reset");

      beginTest();
      for (i = 0; i < 20; i++)
      begin
         hiRand      = $random(seed);
         loRand      = $random(seed);
         addrList[i] = {7'd0, hiRand[30:16]};
         data        = {hiRand[3:0], loRand};
         memWrite(addrList[i], data);
      end
      // Reads in a shuffled order
      for (i = 19; i > 0; i--)
      begin
         pick           = $unsigned($random(seed)) % (i + 1);
         tmpAddr        = addrList[i];
         addrList[i]    = addrList[pick];
         addrList[pick] = tmpAddr;
      end
      for (i = 0; i < 20; i++)
         memRead(addrList[i], 0);
      endTest("random write and read");

      beginTest();
      data     = '0;
      data[3]  = 1'b1;
      data[12] = 1'b1;
      ioWrite(memPkg::statusDev, memPkg::statusReg, data);
      ioRead(memPkg::statusDev, memPkg::statusReg);
      data     = '0;
      data[12] = 1'b1;
      data[35] = 1'b1;
      ioWrite(memPkg::statusDev, memPkg::statusReg, data);
      ioRead(memPkg::statusDev, memPkg::statusReg);
      // PF cleared, then all ones must not bring it back
      ioWrite(memPkg::statusDev, memPkg::statusReg, '0);
      ioRead(memPkg::statusDev, memPkg::statusReg);
      ioWrite(memPkg::statusDev, memPkg::statusReg, '1);
      ioRead(memPkg::statusDev, memPkg::statusReg);
      endTest("status write rules");

      beginTest();
      memWrite(22'(memPkg::memWords) | addrList[0], ~memModel[int'(addrList[0])]);
      ioWrite(4'd1, memPkg::statusReg, '1);
      ioRead(memPkg::statusDev, memPkg::statusReg + 18'd1);
      memRead(addrList[0], 0);
      endTest("nonexistent cycles");

      beginTest();
      fork
         memRead(addrList[1], 0);
         stallClock(2, 20);
      join
      endTest("clock enable stall");

      beginTest();
      ackBefore = ackTotal;
      memRead(addrList[2], 20);
      assert (ackTotal == ackBefore + 1)
         else reportMismatch("ackTotal", 36'(ackBefore + 1), 36'(ackTotal));
      endTest("request held high");

      endRun(1'b0);
   end

endmodule

/* vlog.f */
+incdir+verif
hw/memPkg.sv
hw/waitTimer.sv
hw/memArray.sv
hw/memStatus.sv
hw/memSequencer.sv
hw/memTop.sv
verif/clockGen.sv
verif/memTb.sv

/* Makefile */
SIM     := verilator
FLAGS   := --binary --timing --assert -Wno-fatal
TOP     := memTb
RTL_TOP := memTop
FILES   := vlog.f
OBJ     := obj_dir
PASS    := Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILES) --Mdir $(OBJ)

# Exit status comes from the search for the pass line
run: build
	./$(OBJ)/V$(TOP) | awk '{ print } /$(PASS)/ { ok = 1 } END { exit !ok }'

lint:
	$(SIM) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILES)

clean:
	rm -rf $(OBJ)
